/* src/id_defs.svh */
/*
  Width and instruction field constants for the decode stage.
  Included by the package and by every module that slices the instruction word.
*/

`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Data and address width
`define ID_XLEN 32

// Register index width
`define ID_RADDR_W 5

// Source register 1 field
`define ID_RS1_MSB 19
`define ID_RS1_LSB 15

// Source register 2 field
`define ID_RS2_MSB 24
`define ID_RS2_LSB 20

// Destination register field
`define ID_RD_MSB 11
`define ID_RD_LSB 7

`endif

/* src/id_pkg.sv */
/*
  Types shared across the decode stage.
  Enums for the decoder controls and packed structs for every stage boundary.
*/

`include "id_defs.svh"

package id_pkg;

  typedef logic [`ID_XLEN-1:0]    word_t;
  typedef logic [`ID_RADDR_W-1:0] raddr_t;

  ////////////////////
  // Decoder controls
  ////////////////////

  // ALU operations, compares used by conditional branches
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {JT_JAL, JT_JALR, JT_BCH} jt_sel_e;
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} ctrl_xfer_e;

  // Forwarding source of a register operand
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;

  ////////////////////
  // Stage boundaries
  ////////////////////

  // Fetch to decode
  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  // Bypass selects from the controller
  typedef struct packed {
    fw_sel_e a_sel;
    fw_sel_e b_sel;
    fw_sel_e jalr_sel;
  } byp_sel_t;

  // Decoder output, read by the rest of the stage
  typedef struct packed {
    logic       alu_en;
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    jt_sel_e    jt_sel;
    ctrl_xfer_e ctrl_xfer;
    logic       rf_we;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_type;
    logic       lsu_sign_ext;
    logic       illegal;
  } dec_ctrl_t;

  // ID/EX pipe register contents
  typedef struct packed {
    logic       instr_valid;
    logic       alu_en;
    alu_op_e    alu_op;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic       rf_we;
    raddr_t     rf_waddr;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_type;
    logic       lsu_sign_ext;
    logic       branch_in_ex;
    word_t      pc;
    word_t      instr;
    logic       illegal;
    logic       xif_en;
  } id_ex_t;

  // Coprocessor offload request and response
  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t rs1;
    word_t rs2;
  } xif_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
  } xif_resp_t;

endpackage

/* src/instr_decoder.sv */
/*
  Combinational RV32I decoder for the base ALU, load/store and control-transfer groups.
  Anything else is flagged illegal so the stage can offer it to the coprocessor.
*/

`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
  input  word_t     instr_i,
  output dec_ctrl_t dec_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Quiet defaults with register operands and no side effects
    dec_o              = '0;
    dec_o.alu_op       = ALU_ADD;
    dec_o.op_a_sel     = OP_A_REG;
    dec_o.op_b_sel     = OP_B_REG;
    dec_o.imm_sel      = IMM_I;
    dec_o.jt_sel       = JT_JAL;
    dec_o.ctrl_xfer    = XFER_NONE;

    unique case (opcode)
      // LUI adds the U immediate to zero
      7'b0110111: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_a_sel = OP_A_ZERO;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm_sel  = IMM_U;
        dec_o.rf_we    = 1'b1;
      end
      // AUIPC
      7'b0010111: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_a_sel = OP_A_PC;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm_sel  = IMM_U;
        dec_o.rf_we    = 1'b1;
      end
      // JAL and JALR both write the link address PC + 4
      7'b1101111, 7'b1100111: begin
        dec_o.alu_en    = 1'b1;
        dec_o.op_a_sel  = OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_sel   = IMM_PCINCR;
        dec_o.rf_we     = 1'b1;
        dec_o.jt_sel    = opcode[3] ? JT_JAL : JT_JALR;
        dec_o.ctrl_xfer = opcode[3] ? XFER_JAL : XFER_JALR;
        // JALR only defines funct3 = 000
        if (!opcode[3] && funct3 != 3'b000) dec_o.illegal = 1'b1;
      end
      // Conditional branches with the compare done in the ALU
      7'b1100011: begin
        dec_o.alu_en    = 1'b1;
        dec_o.jt_sel    = JT_BCH;
        dec_o.ctrl_xfer = XFER_BRANCH;
        unique case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      // Loads address memory at rs1 + I immediate
      7'b0000011: begin
        dec_o.alu_en       = 1'b1;
        dec_o.op_b_sel     = OP_B_IMM;
        dec_o.rf_we        = 1'b1;
        dec_o.lsu_en       = 1'b1;
        dec_o.lsu_type     = funct3[1:0];
        dec_o.lsu_sign_ext = !funct3[2];
        // LB LH LW LBU LHU only
        if (funct3[1:0] == 2'b11 || funct3 == 3'b110) dec_o.illegal = 1'b1;
      end
      // Stores address memory at rs1 + S immediate
      7'b0100011: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.imm_sel  = IMM_S;
        dec_o.lsu_en   = 1'b1;
        dec_o.lsu_we   = 1'b1;
        dec_o.lsu_type = funct3[1:0];
        if (funct3[2] || funct3[1:0] == 2'b11) dec_o.illegal = 1'b1;
      end
      // OP-IMM
      7'b0010011: begin
        dec_o.alu_en   = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.rf_we    = 1'b1;
        unique case (funct3)
          3'b000: dec_o.alu_op = ALU_ADD;
          3'b010: dec_o.alu_op = ALU_SLT;
          3'b011: dec_o.alu_op = ALU_SLTU;
          3'b100: dec_o.alu_op = ALU_XOR;
          3'b110: dec_o.alu_op = ALU_OR;
          3'b111: dec_o.alu_op = ALU_AND;
          3'b001: begin
            dec_o.alu_op  = ALU_SLL;
            dec_o.illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // SRLI or SRAI picked by funct7 bit 5
            dec_o.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
            dec_o.illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      // OP with two register sources
      7'b0110011: begin
        dec_o.alu_en = 1'b1;
        dec_o.rf_we  = 1'b1;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
          default:         dec_o.illegal = 1'b1;
        endcase
      end
      default: dec_o.illegal = 1'b1;
    endcase

    // Illegal encodings must not touch the core state
    if (dec_o.illegal) begin
      dec_o.rf_we  = 1'b0;
      dec_o.lsu_en = 1'b0;
      dec_o.alu_en = 1'b0;
    end
  end

endmodule

/* src/operand_select.sv */
/*
  Immediate extraction, register forwarding and operand muxing for ID.
  Also forms the branch target on operand C and the JAL/JALR jump target.
*/

`timescale 1ns/1ps

`include "id_defs.svh"

module operand_select import id_pkg::*; (
  input  word_t     pc_i,
  input  word_t     instr_i,
  input  dec_ctrl_t dec_i,
  input  byp_sel_t  byp_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  input  word_t     fwd_ex_i,
  input  word_t     fwd_wb_i,
  output word_t     operand_a_o,
  output word_t     operand_b_o,
  output word_t     operand_c_o,
  output word_t     rs1_fw_o,
  output word_t     rs2_fw_o,
  output word_t     jmp_target_o
);

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;
  word_t imm_sel;
  word_t jalr_fw;
  word_t bch_target;

  // Same 3:1 choice for rs1, rs2 and the JALR base
  function automatic word_t fw_mux(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    word_t res;
    case (sel)
      FW_EX:   res = ex;
      FW_WB:   res = wb;
      default: res = rf;
    endcase
    return res;
  endfunction

  ////////////////////
  // Immediates
  ////////////////////

  // All sign extended from bit 31
  assign imm_i = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                  instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                  instr_i[20], instr_i[30:21], 1'b0};

  // Immediate feeding operand B
  always_comb begin
    case (dec_i.imm_sel)
      IMM_S:      imm_sel = imm_s;
      IMM_U:      imm_sel = imm_u;
      IMM_PCINCR: imm_sel = word_t'(4);
      default:    imm_sel = imm_i;
    endcase
  end

  ////////////////////
  // Forwarding
  ////////////////////

  assign rs1_fw_o = fw_mux(byp_i.a_sel, rf_rdata_a_i, fwd_ex_i, fwd_wb_i);
  assign rs2_fw_o = fw_mux(byp_i.b_sel, rf_rdata_b_i, fwd_ex_i, fwd_wb_i);
  // JALR base has its own select, it resolves in ID
  assign jalr_fw  = fw_mux(byp_i.jalr_sel, rf_rdata_a_i, fwd_ex_i, fwd_wb_i);

  ////////////////////
  // Operands
  ////////////////////

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw_o;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_sel : rs2_fw_o;

  // Branch target rides to EX on operand C, store data otherwise
  assign bch_target  = pc_i + imm_b;
  assign operand_c_o = (dec_i.ctrl_xfer == XFER_BRANCH) ? bch_target : rs2_fw_o;

  ////////////////////
  // Jump target
  ////////////////////

  always_comb begin
    case (dec_i.jt_sel)
      JT_JAL:  jmp_target_o = pc_i + imm_j;
      // Bit 0 cleared as the spec requires for JALR
      JT_JALR: jmp_target_o = (jalr_fw + imm_i) & ~word_t'(1);
      default: jmp_target_o = bch_target;
    endcase
  end

endmodule

/* src/offload_issue.sv */
/*
  Offers instructions the decoder rejects to an external coprocessor.
  The answer is kept until the instruction leaves ID, so a stalled EX does not repeat the offer.
*/

`timescale 1ns/1ps

module offload_issue import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_ok_i,
  input  dec_ctrl_t dec_i,
  input  word_t     instr_i,
  input  word_t     rs1_i,
  input  word_t     rs2_i,
  input  logic      advance_i,
  input  logic      xif_ready_i,
  input  xif_resp_t xif_resp_i,
  output xif_req_t  xif_req_o,
  output logic      waiting_o,
  output logic      accept_o,
  output logic      writeback_o
);

  logic accepted_q;
  logic rejected_q;
  logic wb_q;
  logic handshake;
  logic reject;

  // Offer only once per instruction
  assign xif_req_o.valid = instr_ok_i && dec_i.illegal && !accepted_q && !rejected_q;
  assign xif_req_o.instr = instr_i;
  assign xif_req_o.rs1   = rs1_i;
  assign xif_req_o.rs2   = rs2_i;

  assign handshake = xif_req_o.valid && xif_ready_i;

  // Stall while the coprocessor has not answered
  assign waiting_o = xif_req_o.valid && !xif_ready_i;

  // Live answer in the handshake cycle, stored answer afterwards
  assign accept_o    = (handshake && xif_resp_i.accept) || accepted_q;
  assign reject      = (handshake && !xif_resp_i.accept) || rejected_q;
  assign writeback_o = (handshake && xif_resp_i.accept && xif_resp_i.writeback) || wb_q;

  // Flags drop as soon as the instruction leaves ID
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      accepted_q <= 1'b0;
      rejected_q <= 1'b0;
      wb_q       <= 1'b0;
    end else begin
      accepted_q <= accept_o && !advance_i;
      rejected_q <= reject && !advance_i;
      wb_q       <= writeback_o && !advance_i;
    end
  end

  // Pending offer stays up on the same instruction until the coprocessor takes it
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    xif_req_o.valid && !xif_ready_i && !advance_i
      |=> xif_req_o.valid && $stable(xif_req_o.instr))
    else $error("offload request dropped or changed before handshake");

endmodule

/* src/id_ex_register.sv */
/*
  Stage handshake logic and the ID/EX pipe register.
  The payload is loaded on a transfer and otherwise held while EX stalls.
*/

`timescale 1ns/1ps

`include "id_defs.svh"

module id_ex_register import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id_i,
  input  logic      kill_i,
  input  logic      halt_i,
  input  logic      ex_ready_i,
  input  dec_ctrl_t dec_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     operand_c_i,
  input  logic      offload_wait_i,
  input  logic      offload_accept_i,
  input  logic      offload_wb_i,
  output logic      instr_ok_o,
  output logic      advance_o,
  output logic      id_valid_o,
  output logic      id_ready_o,
  output id_ex_t    id_ex_o
);

  logic xfer;

  ////////////////////
  // Handshake
  ////////////////////

  // Live instruction that is neither killed nor halted
  assign instr_ok_o = if_id_i.instr_valid && !kill_i && !halt_i;

  assign id_valid_o = instr_ok_o && !offload_wait_i;
  // Kill flushes ID regardless of EX
  assign id_ready_o = kill_i || (ex_ready_i && !halt_i && !offload_wait_i);

  assign xfer = id_valid_o && ex_ready_i;
  // Instruction leaves ID by transfer or by kill
  assign advance_o = xfer || kill_i;

  ////////////////////
  // Pipe register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (xfer) begin
      id_ex_o.instr_valid  <= 1'b1;
      id_ex_o.alu_en       <= dec_i.alu_en;
      id_ex_o.alu_op       <= dec_i.alu_op;
      id_ex_o.operand_a    <= operand_a_i;
      id_ex_o.operand_b    <= operand_b_i;
      id_ex_o.operand_c    <= operand_c_i;
      // Coprocessor may claim rd for an offloaded instruction
      id_ex_o.rf_we        <= dec_i.rf_we || offload_wb_i;
      id_ex_o.rf_waddr     <= if_id_i.instr[`ID_RD_MSB:`ID_RD_LSB];
      id_ex_o.lsu_en       <= dec_i.lsu_en;
      id_ex_o.lsu_we       <= dec_i.lsu_we;
      id_ex_o.lsu_type     <= dec_i.lsu_type;
      id_ex_o.lsu_sign_ext <= dec_i.lsu_sign_ext;
      id_ex_o.branch_in_ex <= (dec_i.ctrl_xfer == XFER_BRANCH);
      id_ex_o.pc           <= if_id_i.pc;
      id_ex_o.instr        <= if_id_i.instr;
      // Accepted offload is no longer an exception
      id_ex_o.illegal      <= dec_i.illegal && !offload_accept_i;
      id_ex_o.xif_en       <= offload_accept_i;
    end else if (ex_ready_i) begin
      // Bubble into EX
      id_ex_o.instr_valid  <= 1'b0;
    end
  end

endmodule

/* src/id_stage.sv */
/*
  Decode stage top. Chains decoder, operand selection, coprocessor offload
  and the ID/EX register; the register file is read through rf_raddr_*.
*/

`timescale 1ns/1ps

`include "id_defs.svh"

module id_stage import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id_i,
  input  byp_sel_t  byp_i,
  input  logic      kill_i,
  input  logic      halt_i,
  output raddr_t    rf_raddr_a_o,
  output raddr_t    rf_raddr_b_o,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,
  input  word_t     fwd_ex_i,
  input  word_t     fwd_wb_i,
  output word_t     jmp_target_o,
  input  logic      ex_ready_i,
  output logic      id_valid_o,
  output logic      id_ready_o,
  output id_ex_t    id_ex_o,
  output xif_req_t  xif_req_o,
  input  logic      xif_ready_i,
  input  xif_resp_t xif_resp_i
);

  dec_ctrl_t dec;
  word_t     operand_a;
  word_t     operand_b;
  word_t     operand_c;
  word_t     rs1_fw;
  word_t     rs2_fw;
  logic      instr_ok;
  logic      advance;
  logic      xif_wait;
  logic      xif_accept;
  logic      xif_wb;

  // Register file read addresses, straight from the instruction word
  assign rf_raddr_a_o = if_id_i.instr[`ID_RS1_MSB:`ID_RS1_LSB];
  assign rf_raddr_b_o = if_id_i.instr[`ID_RS2_MSB:`ID_RS2_LSB];

  instr_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  operand_select u_operand_select (
    .pc_i         (if_id_i.pc),
    .instr_i      (if_id_i.instr),
    .dec_i        (dec),
    .byp_i        (byp_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .fwd_ex_i     (fwd_ex_i),
    .fwd_wb_i     (fwd_wb_i),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .rs1_fw_o     (rs1_fw),
    .rs2_fw_o     (rs2_fw),
    .jmp_target_o (jmp_target_o)
  );

  // Coprocessor sees the forwarded source values
  offload_issue u_offload (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_ok_i  (instr_ok),
    .dec_i       (dec),
    .instr_i     (if_id_i.instr),
    .rs1_i       (rs1_fw),
    .rs2_i       (rs2_fw),
    .advance_i   (advance),
    .xif_ready_i (xif_ready_i),
    .xif_resp_i  (xif_resp_i),
    .xif_req_o   (xif_req_o),
    .waiting_o   (xif_wait),
    .accept_o    (xif_accept),
    .writeback_o (xif_wb)
  );

  id_ex_register u_id_ex (
    .clk              (clk),
    .rst_n            (rst_n),
    .if_id_i          (if_id_i),
    .kill_i           (kill_i),
    .halt_i           (halt_i),
    .ex_ready_i       (ex_ready_i),
    .dec_i            (dec),
    .operand_a_i      (operand_a),
    .operand_b_i      (operand_b),
    .operand_c_i      (operand_c),
    .offload_wait_i   (xif_wait),
    .offload_accept_i (xif_accept),
    .offload_wb_i     (xif_wb),
    .instr_ok_o       (instr_ok),
    .advance_o        (advance),
    .id_valid_o       (id_valid_o),
    .id_ready_o       (id_ready_o),
    .id_ex_o          (id_ex_o)
  );

endmodule

/* test/tb_id_stage.sv */
/*
  Testbench for the decode stage. Drives directed instructions with random register,
  forwarding and PC values, models the coprocessor, and checks the stage with
  concurrent assertions against reference rules kept here.
*/

`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int unsigned DRIVE_DLY = 10;
  localparam int unsigned TIMEOUT   = 20;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // Directed instruction word and whether the coprocessor must see it
  typedef struct packed {
    word_t instr;
    logic  illegal;
  } test_vec_t;

  // Expected ID/EX entry as captured at the transfer edge
  typedef struct packed {
    logic  valid;
    logic  ex_rdy;
    logic  chk_ab;
    logic  chk_c;
    logic  offl;
    logic  accept;
    logic  wb;
    word_t a;
    word_t b;
    word_t c;
  } exp_t;

  logic      clk;
  logic      rst_n;
  if_id_t    if_id_i;
  byp_sel_t  byp_i;
  logic      kill_i;
  logic      halt_i;
  raddr_t    rf_raddr_a_o;
  raddr_t    rf_raddr_b_o;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  word_t     fwd_ex_i;
  word_t     fwd_wb_i;
  word_t     jmp_target_o;
  logic      ex_ready_i;
  logic      id_valid_o;
  logic      id_ready_o;
  id_ex_t    id_ex_o;
  xif_req_t  xif_req_o;
  logic      xif_ready_i;
  xif_resp_t xif_resp_i;

  test_vec_t vecs[$];
  logic      cur_illegal;
  logic      live;
  logic      offer;
  logic      xfer_ref;
  logic      ans_q;
  logic      acc_q;
  logic      wb_q;
  logic      acc_now;
  logic      wb_now;
  logic [6:0] opc;
  word_t     rs1_ref;
  word_t     rs2_ref;
  word_t     jt_ref;
  exp_t      exp_now;
  exp_t      exp_q;

  id_stage u_dut (.*);

  always #50 clk = !clk;

  ////////////////////
  // Reference rules
  ////////////////////

  function automatic word_t i_imm(word_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic word_t s_imm(word_t w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic word_t b_imm(word_t w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic word_t u_imm(word_t w);
    return {w[31:12], 12'b0};
  endfunction

  function automatic word_t j_imm(word_t w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // Register file value unless a bypass is selected
  function automatic word_t pick_source(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
    if (sel == FW_EX) return ex;
    if (sel == FW_WB) return wb;
    return rf;
  endfunction

  // Offer is pending until answered and blocks the transfer
  assign live     = if_id_i.instr_valid && !kill_i && !halt_i;
  assign offer    = live && cur_illegal && !ans_q;
  assign xfer_ref = live && !(offer && !xif_ready_i) && ex_ready_i;
  assign acc_now  = (offer && xif_ready_i) ? xif_resp_i.accept : acc_q;
  assign wb_now   = (offer && xif_ready_i) ? xif_resp_i.writeback : wb_q;

  always_comb begin
    opc     = if_id_i.instr[6:0];
    rs1_ref = pick_source(byp_i.a_sel, rf_rdata_a_i, fwd_ex_i, fwd_wb_i);
    rs2_ref = pick_source(byp_i.b_sel, rf_rdata_b_i, fwd_ex_i, fwd_wb_i);
    exp_now        = '0;
    exp_now.valid  = xfer_ref;
    exp_now.ex_rdy = ex_ready_i;
    exp_now.offl   = cur_illegal;
    exp_now.accept = acc_now;
    exp_now.wb     = wb_now;
    exp_now.chk_ab = !cur_illegal &&
                     (opc inside {OPC_LUI, OPC_LOAD, OPC_STORE, OPC_OPIMM, OPC_OP});
    exp_now.a      = (opc == OPC_LUI) ? '0 : rs1_ref;
    case (opc)
      OPC_OPIMM, OPC_LOAD: exp_now.b = i_imm(if_id_i.instr);
      OPC_STORE:           exp_now.b = s_imm(if_id_i.instr);
      OPC_LUI:             exp_now.b = u_imm(if_id_i.instr);
      default:             exp_now.b = rs2_ref;
    endcase
    exp_now.chk_c  = !cur_illegal && (opc == OPC_BRANCH);
    exp_now.c      = if_id_i.pc + b_imm(if_id_i.instr);
    // JALR base has its own bypass select and bit 0 of the sum is dropped
    if (opc == OPC_JAL) begin
      jt_ref = if_id_i.pc + j_imm(if_id_i.instr);
    end else begin
      jt_ref = (pick_source(byp_i.jalr_sel, rf_rdata_a_i, fwd_ex_i, fwd_wb_i)
                + i_imm(if_id_i.instr)) & ~32'h1;
    end
  end

  // Coprocessor answer lives until the instruction leaves ID
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ans_q <= 1'b0;
      acc_q <= 1'b0;
      wb_q  <= 1'b0;
      exp_q <= '0;
    end else begin
      exp_q <= exp_now;
      if (xfer_ref || kill_i) begin
        ans_q <= 1'b0;
        acc_q <= 1'b0;
        wb_q  <= 1'b0;
      end else if (offer && xif_ready_i) begin
        ans_q <= 1'b1;
        acc_q <= xif_resp_i.accept;
        wb_q  <= xif_resp_i.writeback;
      end
    end
  end

  ////////////////////
  // Failure reporting
  ////////////////////

  task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input word_t got, input word_t exp);
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("Finished with errors");
    $fatal(1);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o == (live && !(offer && !xif_ready_i)))
    else value_error("id_valid_o", $sampled(id_valid_o), !$sampled(id_valid_o));

  // Kill forces ready while back-pressure, halt and a pending offer block it
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    id_ready_o == (kill_i || (ex_ready_i && !halt_i && !(offer && !xif_ready_i))))
    else value_error("id_ready_o", $sampled(id_ready_o), !$sampled(id_ready_o));

  // Register file read ports address rs1 and rs2 of the word in ID
  a_raddr_a: assert property (@(posedge clk) disable iff (!rst_n)
    rf_raddr_a_o == if_id_i.instr[19:15])
    else value_error("rf_raddr_a_o", $sampled(rf_raddr_a_o), $sampled(if_id_i.instr[19:15]));

  a_raddr_b: assert property (@(posedge clk) disable iff (!rst_n)
    rf_raddr_b_o == if_id_i.instr[24:20])
    else value_error("rf_raddr_b_o", $sampled(rf_raddr_b_o), $sampled(if_id_i.instr[24:20]));

  a_req: assert property (@(posedge clk) disable iff (!rst_n) xif_req_o.valid == offer)
    else value_error("xif_req_o.valid", $sampled(xif_req_o.valid), $sampled(offer));

  // Coprocessor sees the word in ID with its forwarded sources
  a_req_data: assert property (@(posedge clk) disable iff (!rst_n)
    xif_req_o.valid |-> xif_req_o.instr == if_id_i.instr && xif_req_o.rs1 == rs1_ref
      && xif_req_o.rs2 == rs2_ref)
    else report_failure("offload request carries the wrong instruction or source values");

  a_entry_valid: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.ex_rdy |-> id_ex_o.instr_valid == exp_q.valid)
    else value_error("id_ex_o.instr_valid", $sampled(id_ex_o.instr_valid),
                     $sampled(exp_q.valid));

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_o))
    else report_failure("ID/EX entry changed while EX was not ready");

  a_op_a: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.chk_ab |-> id_ex_o.operand_a == exp_q.a)
    else value_error("id_ex_o.operand_a", $sampled(id_ex_o.operand_a), $sampled(exp_q.a));

  a_op_b: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.chk_ab |-> id_ex_o.operand_b == exp_q.b)
    else value_error("id_ex_o.operand_b", $sampled(id_ex_o.operand_b), $sampled(exp_q.b));

  a_op_c: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.chk_c |-> id_ex_o.operand_c == exp_q.c)
    else value_error("id_ex_o.operand_c", $sampled(id_ex_o.operand_c), $sampled(exp_q.c));

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.chk_c |-> id_ex_o.branch_in_ex)
    else report_failure("branch_in_ex low after a conditional branch");

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    if_id_i.instr_valid && (opc == OPC_JAL || opc == OPC_JALR) |-> jmp_target_o == jt_ref)
    else value_error("jmp_target_o", $sampled(jmp_target_o), $sampled(jt_ref));

  // Accepted offload is no exception and writes rd as the coprocessor said
  a_off_acc: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.offl && exp_q.accept
      |-> !id_ex_o.illegal && id_ex_o.xif_en && id_ex_o.rf_we == exp_q.wb)
    else report_failure("accepted offload entry has wrong illegal, xif_en or rf_we");

  a_off_rej: assert property (@(posedge clk) disable iff (!rst_n)
    exp_q.valid && exp_q.offl && !exp_q.accept |-> id_ex_o.illegal && !id_ex_o.xif_en)
    else report_failure("rejected offload entry has wrong illegal or xif_en");

  ////////////////////
  // Stimulus
  ////////////////////

  // Drives one instruction and holds it until ID consumes it
  task automatic issue(input word_t instr, input logic illegal, input int unsigned stall_n,
                       input int unsigned halt_n, input logic kill);
    int unsigned cycles;
    int unsigned cop_wait;
    logic        taken;
    cycles              = 0;
    taken               = 1'b0;
    cop_wait            = $urandom_range(0, 3);
    if_id_i.instr_valid = 1'b1;
    if_id_i.pc          = $urandom & 32'hFFFF_FFFC;
    if_id_i.instr       = instr;
    cur_illegal         = illegal;
    rf_rdata_a_i        = $urandom;
    rf_rdata_b_i        = $urandom;
    fwd_ex_i            = $urandom;
    fwd_wb_i            = $urandom;
    byp_i.a_sel         = fw_sel_e'($urandom_range(0, 2));
    byp_i.b_sel         = fw_sel_e'($urandom_range(0, 2));
    byp_i.jalr_sel      = fw_sel_e'($urandom_range(0, 2));
    while (!taken) begin
      ex_ready_i  = (cycles >= stall_n);
      halt_i      = (cycles < halt_n);
      kill_i      = kill;
      // Coprocessor answers a few cycles after the offer appears
      xif_ready_i = illegal && (cycles == halt_n + cop_wait);
      @(negedge clk);
      taken = id_ready_o;
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
      if (cycles > TIMEOUT) report_failure("Timeout waiting for ID to take an instruction");
    end
    if_id_i.instr_valid = 1'b0;
    cur_illegal         = 1'b0;
    kill_i              = 1'b0;
    halt_i              = 1'b0;
    xif_ready_i         = 1'b0;
    ex_ready_i          = 1'b1;
  endtask

  initial begin
    void'($urandom(32'hed85));
    clk          = 1'b0;
    rst_n        = 1'b0;
    if_id_i      = '0;
    byp_i        = '0;
    kill_i       = 1'b0;
    halt_i       = 1'b0;
    rf_rdata_a_i = '0;
    rf_rdata_b_i = '0;
    fwd_ex_i     = '0;
    fwd_wb_i     = '0;
    ex_ready_i   = 1'b1;
    xif_ready_i  = 1'b0;
    xif_resp_i   = '0;
    cur_illegal  = 1'b0;

    vecs.push_back('{32'hFFB10093, 1'b0});  // addi x1, x2, -5
    vecs.push_back('{32'h0101A283, 1'b0});  // lw x5, 16(x3)
    vecs.push_back('{32'hFE622C23, 1'b0});  // sw x6, -8(x4)
    vecs.push_back('{32'h123453B7, 1'b0});  // lui x7, 0x12345
    vecs.push_back('{32'h00A48433, 1'b0});  // add x8, x9, x10
    vecs.push_back('{32'h403100B3, 1'b0});  // sub x1, x2, x3
    vecs.push_back('{32'h7A4020EF, 1'b0});  // jal with a positive offset
    vecs.push_back('{32'hF2DFF0EF, 1'b0});  // jal with a negative offset
    vecs.push_back('{32'h00C280E7, 1'b0});  // jalr x1, 12(x5)
    vecs.push_back('{32'hFFD280E7, 1'b0});  // jalr with odd offset
    vecs.push_back('{32'hFE208EE3, 1'b0});  // beq
    vecs.push_back('{32'h00209463, 1'b0});  // bne
    vecs.push_back('{32'h0000000B, 1'b1});  // custom-0
    vecs.push_back('{32'h02A48433, 1'b1});  // mul is not in the base set
    vecs.push_back('{32'hFFFFFFFF, 1'b1});

    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // First pass streams with coprocessor accepts and the second stalls EX and gets rejects
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < vecs.size(); i++) begin
        xif_resp_i.accept    = (pass == 0);
        xif_resp_i.writeback = i[0];
        issue(vecs[i].instr, vecs[i].illegal, pass * $urandom_range(0, 3), 0, 1'b0);
      end
    end

    // A killed instruction and then one halted for two cycles
    issue(32'h00A48433, 1'b0, 0, 0, 1'b1);
    issue(32'hFFB10093, 1'b0, 0, 2, 1'b0);

    // EX stalls on a valid entry with an empty ID and is released again
    ex_ready_i = 1'b0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    ex_ready_i = 1'b1;
    repeat (3) @(posedge clk);

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* files.f */
+incdir+src
src/id_pkg.sv
src/instr_decoder.sv
src/operand_select.sv
src/offload_issue.sv
src/id_ex_register.sv
src/id_stage.sv
test/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - src
    files:
      - src/id_pkg.sv
      - src/instr_decoder.sv
      - src/operand_select.sv
      - src/offload_issue.sv
      - src/id_ex_register.sv
      - src/id_stage.sv
  - target: test
    files:
      - test/tb_id_stage.sv
